// File: dvi_pkg.sv
package dvi_pkg;

	// ----------------------------------------
	// Raster, 640x480p60 from CEA-861

	localparam int W_COORD  = 11;
	localparam int W_COLOUR = 8;
	localparam int W_SYMBOL = 10;
	localparam int N_LANES  = 3;

	localparam logic [W_COORD-1:0] H_ACTIVE = 11'd640;
	localparam logic [W_COORD-1:0] H_FRONT  = 11'd16;
	localparam logic [W_COORD-1:0] H_SYNC   = 11'd96;
	localparam logic [W_COORD-1:0] H_BACK   = 11'd48;
	localparam logic [W_COORD-1:0] H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 800

	localparam logic [W_COORD-1:0] V_ACTIVE = 11'd480;
	localparam logic [W_COORD-1:0] V_FRONT  = 11'd10;
	localparam logic [W_COORD-1:0] V_SYNC   = 11'd2;
	localparam logic [W_COORD-1:0] V_BACK   = 11'd33;
	localparam logic [W_COORD-1:0] V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 525

	localparam logic SYNC_ACTIVE_LEVEL = 1'b0; // Both syncs negative

	localparam int PATTERN_SHIFT = 2;

	// Lane order on the link
	localparam int LANE_B = 0;
	localparam int LANE_G = 1;
	localparam int LANE_R = 2;

	// ----------------------------------------
	// TMDS coding

	// Indexed by {c1, c0}
	localparam logic [W_SYMBOL-1:0] TMDS_CTRL_00 = 10'b1101010100;
	localparam logic [W_SYMBOL-1:0] TMDS_CTRL_01 = 10'b0010101011;
	localparam logic [W_SYMBOL-1:0] TMDS_CTRL_10 = 10'b0101010100;
	localparam logic [W_SYMBOL-1:0] TMDS_CTRL_11 = 10'b1010101011;

	localparam int W_DISP     = 6;  // Signed running disparity
	localparam int DISP_LIMIT = 10;

	localparam int SKID_DEPTH = 2;

	// ----------------------------------------
	// Types

	typedef struct packed {
		logic                de;
		logic [1:0]          ctrl; // c1, c0
		logic [W_COLOUR-1:0] data;
	} tmds_lane_t;

	typedef struct packed {
		tmds_lane_t [N_LANES-1:0] lane; // 2 red, 1 green, 0 blue
	} pixel_t;

	typedef struct packed {
		logic [N_LANES-1:0][W_SYMBOL-1:0] sym; // Lane 2 in the top field
	} symbol_word_t;

	typedef enum logic [1:0] {
		ACTIVE,
		FRONT,
		SYNC,
		BACK
	} raster_region_e;

	typedef enum logic {
		CTRL,
		DATA
	} tmds_mode_e;

endpackage

// File: video_timing_gen.sv
`timescale 1ns/1ns

module video_timing_gen import dvi_pkg::*; (
	input  logic   i_clk_dvi_pix,
	input  logic   i_rst_n_dvi_pix,
	input  logic   i_ready,
	output pixel_t o_pixel,
	output logic   o_valid
);

// Active first, then front porch, sync, back porch
function automatic raster_region_e classify(
	input logic [W_COORD-1:0] pos,
	input logic [W_COORD-1:0] active,
	input logic [W_COORD-1:0] front,
	input logic [W_COORD-1:0] sync
);
	raster_region_e region;
	if (pos < active)
		region = ACTIVE;
	else if (pos < active + front)
		region = FRONT;
	else if (pos < active + front + sync)
		region = SYNC;
	else
		region = BACK;
	return region;
endfunction

logic [W_COORD-1:0] h_cnt;
logic [W_COORD-1:0] v_cnt;
logic [W_COORD-1:0] frame_cnt;

raster_region_e     h_region;
raster_region_e     v_region;
logic               de;
logic               hsync;
logic               vsync;
logic [W_COORD-1:0] red_sum;
logic [W_COORD-1:0] green_sum;
pixel_t             pixel_next;

// ----------------------------------------
// Raster counters

always_ff @(posedge i_clk_dvi_pix or negedge i_rst_n_dvi_pix) begin
	if (!i_rst_n_dvi_pix) begin
		h_cnt <= '0;
		v_cnt <= '0;
		frame_cnt <= '0;
	end else if (i_ready) begin
		if (h_cnt == H_TOTAL - 1'b1) begin
			h_cnt <= '0;
			if (v_cnt == V_TOTAL - 1'b1) begin
				v_cnt <= '0;
				frame_cnt <= frame_cnt + 1'b1; // Free running, wraps
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end
end

// ----------------------------------------
// Syncs, enable and pattern

assign h_region = classify(h_cnt, H_ACTIVE, H_FRONT, H_SYNC);
assign v_region = classify(v_cnt, V_ACTIVE, V_FRONT, V_SYNC);

assign de    = (h_region == ACTIVE) && (v_region == ACTIVE);
assign hsync = (h_region == SYNC) ? SYNC_ACTIVE_LEVEL : ~SYNC_ACTIVE_LEVEL;
assign vsync = (v_region == SYNC) ? SYNC_ACTIVE_LEVEL : ~SYNC_ACTIVE_LEVEL;

assign red_sum   = h_cnt + frame_cnt;
assign green_sum = v_cnt + frame_cnt;

always_comb begin
	pixel_next = '0;
	pixel_next.lane[LANE_B].ctrl = {vsync, hsync}; // Only blue carries syncs
	pixel_next.lane[LANE_B].de = de;
	pixel_next.lane[LANE_G].de = de;
	pixel_next.lane[LANE_R].de = de;
	if (de) begin
		pixel_next.lane[LANE_R].data = W_COLOUR'(red_sum << PATTERN_SHIFT);
		pixel_next.lane[LANE_G].data = W_COLOUR'(green_sum << PATTERN_SHIFT);
		pixel_next.lane[LANE_B].data = W_COLOUR'(frame_cnt);
	end
end

// ----------------------------------------
// Output register

always_ff @(posedge i_clk_dvi_pix or negedge i_rst_n_dvi_pix) begin
	if (!i_rst_n_dvi_pix)
		o_valid <= 1'b0;
	else if (i_ready)
		o_valid <= 1'b1; // Every raster position makes a word
end

always_ff @(posedge i_clk_dvi_pix) begin
	if (i_ready)
		o_pixel <= pixel_next;
end

// Counter never leaves the line, even across stalls
a_h_in_range: assert property (
	@(posedge i_clk_dvi_pix) disable iff (!i_rst_n_dvi_pix)
	h_cnt < H_TOTAL
) else $error("h_cnt out of range: %0d", h_cnt);

endmodule

// File: tmds_encoder.sv
`timescale 1ns/1ns

module tmds_encoder import dvi_pkg::*; (
	input  logic                i_clk_dvi_pix,
	input  logic                i_rst_n_dvi_pix,
	input  logic                i_en,
	input  tmds_lane_t          i_lane,
	input  logic                i_valid,
	output logic [W_SYMBOL-1:0] o_symbol,
	output logic                o_valid
);

tmds_mode_e               mode;
logic [3:0]               n1_data;
logic                     use_xnor;
logic [W_COLOUR:0]        q_m;     // Bit 8 flags XOR
logic [3:0]               n1_qm;
logic signed [W_DISP-1:0] balance; // Ones minus zeros of q_m[7:0]
logic signed [W_DISP-1:0] qm8_x2;
logic signed [W_DISP-1:0] nqm8_x2;
logic signed [W_DISP-1:0] disp;
logic signed [W_DISP-1:0] disp_next;
logic [W_SYMBOL-1:0]      symbol_next;

assign mode = i_lane.de ? DATA : CTRL;

// ----------------------------------------
// Transition minimisation

assign n1_data  = 4'($countones(i_lane.data));
assign use_xnor = (n1_data > 4'd4) || ((n1_data == 4'd4) && !i_lane.data[0]);

always_comb begin
	q_m[0] = i_lane.data[0];
	for (int i = 1; i < W_COLOUR; i++)
		q_m[i] = use_xnor ? ~(q_m[i-1] ^ i_lane.data[i]) : (q_m[i-1] ^ i_lane.data[i]);
	q_m[W_COLOUR] = ~use_xnor;
end

assign n1_qm   = 4'($countones(q_m[W_COLOUR-1:0]));
assign balance = $signed({1'b0, n1_qm, 1'b0}) - 6'sd8;
assign qm8_x2  = $signed({{(W_DISP-2){1'b0}}, q_m[8], 1'b0});
assign nqm8_x2 = $signed({{(W_DISP-2){1'b0}}, ~q_m[8], 1'b0});

// ----------------------------------------
// DC balance and control symbols

always_comb begin
	symbol_next = '0;
	disp_next = disp;
	case (mode)
		CTRL: begin
			disp_next = '0; // Blanking restarts the balance
			case (i_lane.ctrl)
				2'b00: symbol_next = TMDS_CTRL_00;
				2'b01: symbol_next = TMDS_CTRL_01;
				2'b10: symbol_next = TMDS_CTRL_10;
				default: symbol_next = TMDS_CTRL_11;
			endcase
		end
		DATA: begin
			if (disp == 0 || balance == 0) begin
				symbol_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
				disp_next = q_m[8] ? disp + balance : disp - balance;
			end else if ((disp > 0) == (balance > 0)) begin
				// Same sign, invert to pull back toward zero
				symbol_next = {1'b1, q_m[8], ~q_m[7:0]};
				disp_next = disp + qm8_x2 - balance;
			end else begin
				symbol_next = {1'b0, q_m[8], q_m[7:0]};
				disp_next = disp - nqm8_x2 + balance;
			end
		end
		default: begin
			symbol_next = TMDS_CTRL_00;
		end
	endcase
end

// ----------------------------------------
// Pipeline register

always_ff @(posedge i_clk_dvi_pix or negedge i_rst_n_dvi_pix) begin
	if (!i_rst_n_dvi_pix) begin
		o_valid <= 1'b0;
		disp <= '0;
	end else if (i_en) begin
		o_valid <= i_valid;
		if (i_valid)
			disp <= disp_next;
	end
end

always_ff @(posedge i_clk_dvi_pix) begin
	if (i_en && i_valid)
		o_symbol <= symbol_next;
end

// Balance must stay bounded over any run of data symbols
a_disp_bounded: assert property (
	@(posedge i_clk_dvi_pix) disable iff (!i_rst_n_dvi_pix)
	i_en && i_valid |=> (disp <= DISP_LIMIT) && (disp >= -DISP_LIMIT)
) else $error("Running disparity out of range: %0d", disp);

endmodule

// File: tmds_link_out.sv
`timescale 1ns/1ns

module tmds_link_out import dvi_pkg::*; (
	input  logic         i_clk_dvi_pix,
	input  logic         i_rst_n_dvi_pix,
	input  symbol_word_t i_symbols,
	input  logic         i_valid,
	output logic         o_stage_ready,
	output symbol_word_t o_symbols,
	output logic         o_valid,
	input  logic         i_ready
);

symbol_word_t                    entry [SKID_DEPTH];
logic [$clog2(SKID_DEPTH)-1:0]   rd_ptr;
logic [$clog2(SKID_DEPTH)-1:0]   wr_ptr;
logic [$clog2(SKID_DEPTH+1)-1:0] count;
logic                            bypass;
logic                            push;
logic                            pop;

// Upstream only looks at our fill level and never at i_ready
assign o_stage_ready = (count < SKID_DEPTH);

// ----------------------------------------
// Output side

assign bypass    = (count == '0); // When empty the encoder word goes straight out
assign o_valid   = !bypass || i_valid;
assign o_symbols = bypass ? i_symbols : entry[rd_ptr];

assign pop  = !bypass && i_ready;
assign push = i_valid && o_stage_ready && !(bypass && i_ready);

// ----------------------------------------
// Entry storage

always_ff @(posedge i_clk_dvi_pix or negedge i_rst_n_dvi_pix) begin
	if (!i_rst_n_dvi_pix) begin
		rd_ptr <= '0;
		wr_ptr <= '0;
		count <= '0;
	end else begin
		if (push)
			wr_ptr <= wr_ptr + 1'b1;
		if (pop)
			rd_ptr <= rd_ptr + 1'b1;
		count <= count + ($bits(count))'(push) - ($bits(count))'(pop);
	end
end

always_ff @(posedge i_clk_dvi_pix) begin
	if (push)
		entry[wr_ptr] <= i_symbols;
end

// Held word may not change even across the move from bypass into the buffer
a_hold_stable: assert property (
	@(posedge i_clk_dvi_pix) disable iff (!i_rst_n_dvi_pix)
	o_valid && !i_ready |=> o_valid && $stable(o_symbols)
) else $error("o_symbols changed while stalled");

endmodule

// File: dvi_tx_top.sv
`timescale 1ns/1ns

module dvi_tx_top import dvi_pkg::*; (
	input  logic         clk_dvi_pix,
	input  logic         rst_n_dvi_pix,
	input  logic         i_ready,
	output symbol_word_t o_symbols,
	output logic         o_valid
);

pixel_t             pixel;
logic               pixel_valid;
logic               stage_ready;   // From the skid buffer to every stage
symbol_word_t       enc_word;
logic [N_LANES-1:0] lane_valid;

// ----------------------------------------
// Timing and pattern

video_timing_gen i_video_timing_gen (
	.i_clk_dvi_pix   (clk_dvi_pix),
	.i_rst_n_dvi_pix (rst_n_dvi_pix),
	.i_ready         (stage_ready),
	.o_pixel         (pixel),
	.o_valid         (pixel_valid)
);

// ----------------------------------------
// One encoder per colour lane

for (genvar lane = 0; lane < N_LANES; lane++) begin : g_lane
	tmds_encoder i_tmds_encoder (
		.i_clk_dvi_pix   (clk_dvi_pix),
		.i_rst_n_dvi_pix (rst_n_dvi_pix),
		.i_en            (stage_ready),
		.i_lane          (pixel.lane[lane]),
		.i_valid         (pixel_valid),
		.o_symbol        (enc_word.sym[lane]),
		.o_valid         (lane_valid[lane])
	);
end

// Lanes share one enable, so lane 0 speaks for all
tmds_link_out i_tmds_link_out (
	.i_clk_dvi_pix   (clk_dvi_pix),
	.i_rst_n_dvi_pix (rst_n_dvi_pix),
	.i_symbols       (enc_word),
	.i_valid         (lane_valid[LANE_B]),
	.o_stage_ready   (stage_ready),
	.o_symbols       (o_symbols),
	.o_valid         (o_valid),
	.i_ready         (i_ready)
);

endmodule

// File: tb_dvi_model.svh
`ifndef TB_DVI_MODEL_SVH
`define TB_DVI_MODEL_SVH

// ----------------------------------------
// Back-pressure source

function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// ----------------------------------------
// Expected pixel for one raster position

function automatic pixel_t raster_pixel(input int h, input int v, input int frame);
	pixel_t px;
	int     h_sync_start;
	int     v_sync_start;
	logic   de;
	logic   hs;
	logic   vs;
	h_sync_start = int'(H_ACTIVE) + int'(H_FRONT);
	v_sync_start = int'(V_ACTIVE) + int'(V_FRONT);
	de = (h < int'(H_ACTIVE)) && (v < int'(V_ACTIVE));
	hs = ~SYNC_ACTIVE_LEVEL;
	vs = ~SYNC_ACTIVE_LEVEL;
	if (h >= h_sync_start && h < h_sync_start + int'(H_SYNC))
		hs = SYNC_ACTIVE_LEVEL;
	if (v >= v_sync_start && v < v_sync_start + int'(V_SYNC))
		vs = SYNC_ACTIVE_LEVEL;
	px = '0;
	for (int l = 0; l < N_LANES; l++)
		px.lane[l].de = de;
	px.lane[LANE_B].ctrl = {vs, hs}; // Green and red stay at 00
	if (de) begin
		px.lane[LANE_R].data = W_COLOUR'((h + frame) << PATTERN_SHIFT);
		px.lane[LANE_G].data = W_COLOUR'((v + frame) << PATTERN_SHIFT);
		px.lane[LANE_B].data = W_COLOUR'(frame);
	end
	return px;
endfunction

// ----------------------------------------
// DVI 1.0 TMDS encoder, one symbol

function automatic logic [W_SYMBOL-1:0] tmds_encode(input tmds_lane_t lane, inout int disp);
	logic [8:0] q_m;
	logic [9:0] q_out;
	logic       xnor_sel;
	int         n1_d;
	int         n1_q;
	int         n0_q;
	if (!lane.de) begin
		disp = 0;
		case (lane.ctrl)
			2'b00: q_out = TMDS_CTRL_00;
			2'b01: q_out = TMDS_CTRL_01;
			2'b10: q_out = TMDS_CTRL_10;
			default: q_out = TMDS_CTRL_11;
		endcase
		return q_out;
	end
	n1_d = 0;
	for (int i = 0; i < 8; i++)
		if (lane.data[i])
			n1_d++;
	xnor_sel = (n1_d > 4) || (n1_d == 4 && lane.data[0] == 1'b0);
	q_m[0] = lane.data[0];
	for (int i = 1; i < 8; i++)
		q_m[i] = xnor_sel ? ~(q_m[i-1] ^ lane.data[i]) : (q_m[i-1] ^ lane.data[i]);
	q_m[8] = xnor_sel ? 1'b0 : 1'b1;
	n1_q = 0;
	for (int i = 0; i < 8; i++)
		if (q_m[i])
			n1_q++;
	n0_q = 8 - n1_q;
	if (disp == 0 || n1_q == n0_q) begin
		q_out = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
		disp = q_m[8] ? disp + n1_q - n0_q : disp + n0_q - n1_q;
	end else if ((disp > 0 && n1_q > n0_q) || (disp < 0 && n0_q > n1_q)) begin
		q_out = {1'b1, q_m[8], ~q_m[7:0]}; // Inverted to pull the balance back
		disp = disp + (q_m[8] ? 2 : 0) + n0_q - n1_q;
	end else begin
		q_out = {1'b0, q_m[8], q_m[7:0]};
		disp = disp - (q_m[8] ? 0 : 2) + n1_q - n0_q;
	end
	return q_out;
endfunction

`endif

// File: tb_dvi_tx.sv
`timescale 1ns/1ns

module tb_dvi_tx import dvi_pkg::*; ();

localparam int          N_WORDS        = 462000;      // 1.1 frames of 800x525
localparam int          TIMEOUT_CYCLES = 2 * N_WORDS;
localparam logic [31:0] LCG_SEED       = 32'h0af67ec6;

logic         clk_dvi_pix;
logic         rst_n_dvi_pix;
logic         i_ready;
symbol_word_t o_symbols;
logic         o_valid;

logic [31:0]  lcg_state;
int           cycle_count;
int           words_checked;
int           edges_after_reset;
int           exp_h;
int           exp_v;
int           exp_frame;
int           disp [N_LANES];   // Running disparity per lane
logic         held_pending;
symbol_word_t held_word;

`include "tb_dvi_model.svh"

dvi_tx_top i_dvi_tx_top (
	.clk_dvi_pix   (clk_dvi_pix),
	.rst_n_dvi_pix (rst_n_dvi_pix),
	.i_ready       (i_ready),
	.o_symbols     (o_symbols),
	.o_valid       (o_valid)
);

always #5 clk_dvi_pix = ~clk_dvi_pix;

task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("Error: %s = 0x%0h, expected 0x%0h (word %0d)", name, actual, expected,
			words_checked);
		$display("Test failed");
		$fatal(1, "Stopped at the first mismatch");
	end
endtask

// ----------------------------------------
// Reset, ready stimulus and end of run

initial begin
	clk_dvi_pix = 1'b0;
	rst_n_dvi_pix = 1'b0;
	i_ready = 1'b0;
	lcg_state = LCG_SEED;
	cycle_count = 0;
	words_checked = 0;
	edges_after_reset = 0;
	exp_h = 0;
	exp_v = 0;
	exp_frame = 0;
	held_pending = 1'b0;
	held_word = '0;
	for (int l = 0; l < N_LANES; l++)
		disp[l] = 0;
	repeat (4) @(negedge clk_dvi_pix);
	rst_n_dvi_pix = 1'b1;
	wait (words_checked == N_WORDS);
	@(negedge clk_dvi_pix);
	$display("Test passed");
	$finish;
end

always @(negedge clk_dvi_pix) begin
	lcg_state = lcg_next(lcg_state);
	i_ready = (lcg_state[31:30] != 2'b00); // Low about one cycle in four
end

// ----------------------------------------
// Compare at each rising edge

always @(posedge clk_dvi_pix) begin
	pixel_t              exp_pixel;
	logic [W_SYMBOL-1:0] exp_sym;
	int                  d;
	if (rst_n_dvi_pix && words_checked < N_WORDS) begin
		// Two register stages before the first word
		if (edges_after_reset < 2) begin
			check_value("o_valid", 32'(o_valid), 32'd0);
			edges_after_reset++;
		end
		if (held_pending) begin
			check_value("o_valid", 32'(o_valid), 32'd1);
			check_value("o_symbols", 32'(o_symbols), 32'(held_word));
		end
		held_pending = o_valid && !i_ready;
		held_word = o_symbols;
		if (o_valid && i_ready) begin
			exp_pixel = raster_pixel(exp_h, exp_v, exp_frame);
			for (int l = 0; l < N_LANES; l++) begin
				d = disp[l];
				exp_sym = tmds_encode(exp_pixel.lane[l], d);
				disp[l] = d;
				check_value($sformatf("o_symbols.sym[%0d]", l), 32'(o_symbols.sym[l]),
					32'(exp_sym));
			end
			if (exp_h == int'(H_TOTAL) - 1) begin
				exp_h = 0;
				if (exp_v == int'(V_TOTAL) - 1) begin
					exp_v = 0;
					exp_frame++; // Next frame shifts the whole pattern
				end else begin
					exp_v++;
				end
			end else begin
				exp_h++;
			end
			words_checked++;
		end
	end
end

always @(posedge clk_dvi_pix) begin
	cycle_count++;
	if (cycle_count >= TIMEOUT_CYCLES) begin
		$display("Timed out after %0d cycles with %0d of %0d words checked", cycle_count,
			words_checked, N_WORDS);
		$display("Test failed");
		$fatal(1, "Cycle limit reached");
	end
end

endmodule

// File: all.f
+incdir+.
dvi_pkg.sv
video_timing_gen.sv
tmds_encoder.sv
tmds_link_out.sv
dvi_tx_top.sv
tb_dvi_tx.sv

// File: Makefile
# Verilator build and run for the DVI transmitter testbench

VERILATOR ?= verilator
TOP       ?= tb_dvi_tx
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= Test passed

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
